// ==== hdl/stap_jtag_pkg.sv ====
package stap_jtag_pkg;

    // ------------------------------
    // Instruction register
    // ------------------------------
    localparam int IR_WIDTH = 4;

    // Loaded into the IR chain in Capture-IR, LSB pair is 01 as 1149.1 requires
    localparam logic [IR_WIDTH-1:0] IR_CAPTURE = 4'b0001;

    // Opcodes
    localparam logic [IR_WIDTH-1:0] OP_IDCODE     = 4'h1;
    localparam logic [IR_WIDTH-1:0] OP_TDR        = 4'h8;
    localparam logic [IR_WIDTH-1:0] OP_SEC_STATUS = 4'h9;
    localparam logic [IR_WIDTH-1:0] OP_BYPASS     = 4'hF;

    // ------------------------------
    // TAP controller state codes
    // ------------------------------
    localparam logic [3:0] TEST_LOGIC_RESET = 4'hF;
    localparam logic [3:0] RUN_TEST_IDLE    = 4'hC;
    localparam logic [3:0] SELECT_DR_SCAN   = 4'h7;
    localparam logic [3:0] CAPTURE_DR       = 4'h6;
    localparam logic [3:0] SHIFT_DR         = 4'h2;
    localparam logic [3:0] EXIT1_DR         = 4'h1;
    localparam logic [3:0] PAUSE_DR         = 4'h3;
    localparam logic [3:0] EXIT2_DR         = 4'h0;
    localparam logic [3:0] UPDATE_DR        = 4'h5;
    localparam logic [3:0] SELECT_IR_SCAN   = 4'h4;
    localparam logic [3:0] CAPTURE_IR       = 4'hE;
    localparam logic [3:0] SHIFT_IR         = 4'hA;
    localparam logic [3:0] EXIT1_IR         = 4'h9;
    localparam logic [3:0] PAUSE_IR         = 4'hB;
    localparam logic [3:0] EXIT2_IR         = 4'h8;
    localparam logic [3:0] UPDATE_IR        = 4'hD;

endpackage

// ==== hdl/stap_secure_pkg.sv ====
package stap_secure_pkg;

    // ------------------------------
    // Debug security policy
    // ------------------------------

    // Width of the policy bus from the fuse or security controller
    localparam int POLICY_WIDTH = 4;

    // Policy codes
    // Anything not listed here is treated as locked
    localparam logic [POLICY_WIDTH-1:0] POLICY_LOCKED   = 4'h0;
    localparam logic [POLICY_WIDTH-1:0] POLICY_DEFAULT  = 4'h1;
    localparam logic [POLICY_WIDTH-1:0] POLICY_UNLOCKED = 4'h2;

    // ------------------------------
    // Security status register
    // ------------------------------

    // Layout of the captured word
    //   [3:0]  latched policy
    //   [4]    TDR access enable
    //   [7:5]  zero
    localparam int STATUS_WIDTH = 8;

endpackage

// ==== hdl/stap_tap_fsm.sv ====
module stap_tap_fsm (
    input  logic ftap_tck,
    input  logic rst_n,
    input  logic ftap_tms,
    output logic tap_reset,
    output logic capture_ir,
    output logic shift_ir,
    output logic update_ir,
    output logic capture_dr,
    output logic shift_dr,
    output logic update_dr,
    output logic select_ir
);

    import stap_jtag_pkg::*;

    logic [3:0] state;
    logic [3:0] state_nxt;

    // ------------------------------
    // Next-state table
    // ------------------------------

    // Standard 1149.1 diagram, one step per TCK rising edge
    always_comb begin
        case (state)
            TEST_LOGIC_RESET: state_nxt = ftap_tms ? TEST_LOGIC_RESET : RUN_TEST_IDLE;
            RUN_TEST_IDLE:    state_nxt = ftap_tms ? SELECT_DR_SCAN   : RUN_TEST_IDLE;
            // DR column
            SELECT_DR_SCAN:   state_nxt = ftap_tms ? SELECT_IR_SCAN   : CAPTURE_DR;
            CAPTURE_DR:       state_nxt = ftap_tms ? EXIT1_DR         : SHIFT_DR;
            SHIFT_DR:         state_nxt = ftap_tms ? EXIT1_DR         : SHIFT_DR;
            EXIT1_DR:         state_nxt = ftap_tms ? UPDATE_DR        : PAUSE_DR;
            PAUSE_DR:         state_nxt = ftap_tms ? EXIT2_DR         : PAUSE_DR;
            EXIT2_DR:         state_nxt = ftap_tms ? UPDATE_DR        : SHIFT_DR;
            UPDATE_DR:        state_nxt = ftap_tms ? SELECT_DR_SCAN   : RUN_TEST_IDLE;
            // IR column
            SELECT_IR_SCAN:   state_nxt = ftap_tms ? TEST_LOGIC_RESET : CAPTURE_IR;
            CAPTURE_IR:       state_nxt = ftap_tms ? EXIT1_IR         : SHIFT_IR;
            SHIFT_IR:         state_nxt = ftap_tms ? EXIT1_IR         : SHIFT_IR;
            EXIT1_IR:         state_nxt = ftap_tms ? UPDATE_IR        : PAUSE_IR;
            PAUSE_IR:         state_nxt = ftap_tms ? EXIT2_IR         : PAUSE_IR;
            EXIT2_IR:         state_nxt = ftap_tms ? UPDATE_IR        : SHIFT_IR;
            UPDATE_IR:        state_nxt = ftap_tms ? SELECT_DR_SCAN   : RUN_TEST_IDLE;
            default:          state_nxt = TEST_LOGIC_RESET;
        endcase
    end

    // State register
    // rst_n low lands in Test-Logic-Reset on the next edge
    always_ff @(posedge ftap_tck) begin
        if (!rst_n) begin
            state <= TEST_LOGIC_RESET;
        end else begin
            state <= state_nxt;
        end
    end

    // ------------------------------
    // Strobe decode
    // ------------------------------

    // Decoded from the state flops only, so no TMS path reaches a strobe
    assign tap_reset  = (state == TEST_LOGIC_RESET);
    assign capture_ir = (state == CAPTURE_IR);
    assign shift_ir   = (state == SHIFT_IR);
    assign update_ir  = (state == UPDATE_IR);
    assign capture_dr = (state == CAPTURE_DR);
    assign shift_dr   = (state == SHIFT_DR);
    assign update_dr  = (state == UPDATE_DR);

    // IR column steers the TDO mux
    assign select_ir = (state == SELECT_IR_SCAN) ||
                       (state == CAPTURE_IR)     ||
                       (state == SHIFT_IR)       ||
                       (state == EXIT1_IR)       ||
                       (state == PAUSE_IR)       ||
                       (state == EXIT2_IR)       ||
                       (state == UPDATE_IR);

endmodule

// ==== hdl/stap_instr_reg.sv ====
module stap_instr_reg (
    input  logic ftap_tck,
    input  logic rst_n,
    input  logic ftap_tdi,
    input  logic tap_reset,
    input  logic capture_ir,
    input  logic shift_ir,
    input  logic update_ir,
    output logic ir_tdo,
    output logic sel_idcode,
    output logic sel_tdr,
    output logic sel_status
);

    import stap_jtag_pkg::*;

    logic [IR_WIDTH-1:0] ir_shift;
    logic [IR_WIDTH-1:0] ir_q;

    // ------------------------------
    // Shift chain
    // ------------------------------

    // Capture loads the fixed pattern
    // Shift brings TDI in at the MSB
    always_ff @(posedge ftap_tck) begin
        if (capture_ir) begin
            ir_shift <= IR_CAPTURE;
        end else if (shift_ir) begin
            ir_shift <= {ftap_tdi, ir_shift[IR_WIDTH-1:1]};
        end
    end

    // LSB drives TDO while the IR column is active
    assign ir_tdo = ir_shift[0];

    // ------------------------------
    // Update latch
    // ------------------------------

    // Test-Logic-Reset brings IDCODE back as the current instruction
    always_ff @(posedge ftap_tck) begin
        if (!rst_n || tap_reset) begin
            ir_q <= OP_IDCODE;
        end else if (update_ir) begin
            ir_q <= ir_shift;
        end
    end

    // Opcode decode into one-hot DR selects
    // No select high means the bypass cell is in the path
    always_comb begin
        sel_idcode = 1'b0;
        sel_tdr    = 1'b0;
        sel_status = 1'b0;
        case (ir_q)
            OP_IDCODE:     sel_idcode = 1'b1;
            OP_TDR:        sel_tdr    = 1'b1;
            OP_SEC_STATUS: sel_status = 1'b1;
            // Explicit bypass and all unknown codes leave every select low
            default: ;
        endcase
    end

endmodule

// ==== hdl/stap_secure_plugin.sv ====
module stap_secure_plugin (
    input  logic                                     ftap_tck,
    input  logic                                     rst_n,
    input  logic [stap_secure_pkg::POLICY_WIDTH-1:0] fdfx_secure_policy,
    input  logic                                     fdfx_policy_update,
    input  logic                                     fdfx_earlyboot_exit,
    output logic [stap_secure_pkg::POLICY_WIDTH-1:0] policy_q,
    output logic                                     tdr_access_en,
    output logic                                     dfxsecure_feature_en
);

    import stap_secure_pkg::*;

    logic [POLICY_WIDTH-1:0] policy_d;
    logic                    access_d;
    logic                    access_q;

    // ------------------------------
    // Policy latch
    // ------------------------------

    // New policy only on the update strobe
    assign policy_d = fdfx_policy_update ? fdfx_secure_policy : policy_q;

    // Unlocked always opens
    // Default opens only until early boot is done
    // Locked and unknown codes stay closed
    always_comb begin
        case (policy_d)
            POLICY_UNLOCKED: access_d = 1'b1;
            POLICY_DEFAULT:  access_d = !fdfx_earlyboot_exit;
            default:         access_d = 1'b0;
        endcase
    end

    // Powers up locked with the feature disabled
    always_ff @(posedge ftap_tck) begin
        if (!rst_n) begin
            policy_q <= POLICY_LOCKED;
            access_q <= 1'b0;
        end else begin
            policy_q <= policy_d;
            access_q <= access_d;
        end
    end

    // Decision goes to the DR bank and out to the SoC from the same flop
    assign tdr_access_en        = access_q;
    assign dfxsecure_feature_en = access_q;

endmodule

// ==== hdl/stap_dr_bank.sv ====
module stap_dr_bank #(
    parameter int          TDR_WIDTH    = 32,
    parameter logic [31:0] IDCODE_VALUE = 32'h0A5B_C0DF
) (
    input  logic                                 ftap_tck,
    input  logic                                 rst_n,
    input  logic                                 ftap_tdi,
    input  logic                                 capture_dr,
    input  logic                                 shift_dr,
    input  logic                                 update_dr,
    input  logic                                 sel_idcode,
    input  logic                                 sel_tdr,
    input  logic                                 sel_status,
    input  logic                                 tdr_access_en,
    input  logic [stap_secure_pkg::POLICY_WIDTH-1:0] policy_q,
    input  logic [TDR_WIDTH-1:0]                 tdr_data_in,
    output logic                                 dr_tdo,
    output logic [TDR_WIDTH-1:0]                 tdr_data_out
);

    import stap_secure_pkg::*;

    logic                    tdr_active;
    logic                    bypass_active;
    logic                    bypass_q;
    logic [31:0]             idcode_sr;
    logic [STATUS_WIDTH-1:0] status_sr;
    logic [STATUS_WIDTH-1:0] status_cap;
    logic [TDR_WIDTH-1:0]    tdr_sr;

    // ------------------------------
    // Chain selection
    // ------------------------------

    // A locked TDR falls back to the bypass cell
    assign tdr_active    = sel_tdr && tdr_access_en;
    assign bypass_active = !(sel_idcode || sel_status || tdr_active);

    // Bypass cell captures zero
    always_ff @(posedge ftap_tck) begin
        if (capture_dr && bypass_active) begin
            bypass_q <= 1'b0;
        end else if (shift_dr && bypass_active) begin
            bypass_q <= ftap_tdi;
        end
    end

    // IDCODE chain
    // Bit 0 is always 1 per 1149.1
    always_ff @(posedge ftap_tck) begin
        if (capture_dr && sel_idcode) begin
            idcode_sr <= {IDCODE_VALUE[31:1], 1'b1};
        end else if (shift_dr && sel_idcode) begin
            idcode_sr <= {ftap_tdi, idcode_sr[31:1]};
        end
    end

    // Security status snapshot
    assign status_cap = {{(STATUS_WIDTH-POLICY_WIDTH-1){1'b0}}, tdr_access_en, policy_q};

    always_ff @(posedge ftap_tck) begin
        if (capture_dr && sel_status) begin
            status_sr <= status_cap;
        end else if (shift_dr && sel_status) begin
            status_sr <= {ftap_tdi, status_sr[STATUS_WIDTH-1:1]};
        end
    end

    // ------------------------------
    // Test data register
    // ------------------------------

    // Captures the parallel input only while access is granted
    always_ff @(posedge ftap_tck) begin
        if (capture_dr && tdr_active) begin
            tdr_sr <= tdr_data_in;
        end else if (shift_dr && tdr_active) begin
            tdr_sr <= {ftap_tdi, tdr_sr[TDR_WIDTH-1:1]};
        end
    end

    // Parallel output holds its value across locked updates
    always_ff @(posedge ftap_tck) begin
        if (!rst_n) begin
            tdr_data_out <= '0;
        end else if (update_dr && tdr_active) begin
            tdr_data_out <= tdr_sr;
        end
    end

    // LSB of the selected chain
    always_comb begin
        if (sel_idcode) begin
            dr_tdo = idcode_sr[0];
        end else if (sel_status) begin
            dr_tdo = status_sr[0];
        end else if (tdr_active) begin
            dr_tdo = tdr_sr[0];
        end else begin
            dr_tdo = bypass_q;
        end
    end

endmodule

// ==== hdl/stap_top.sv ====
module stap_top #(
    parameter int          TDR_WIDTH    = 32,
    parameter logic [31:0] IDCODE_VALUE = 32'h0A5B_C0DF
) (
    input  logic                                     ftap_tck,
    input  logic                                     rst_n,
    input  logic                                     ftap_tms,
    input  logic                                     ftap_tdi,
    input  logic [stap_secure_pkg::POLICY_WIDTH-1:0] fdfx_secure_policy,
    input  logic                                     fdfx_policy_update,
    input  logic                                     fdfx_earlyboot_exit,
    input  logic [TDR_WIDTH-1:0]                     tdr_data_in,
    output logic                                     atap_tdo,
    output logic [TDR_WIDTH-1:0]                     tdr_data_out,
    output logic                                     dfxsecure_feature_en
);

    logic tap_reset;
    logic capture_ir;
    logic shift_ir;
    logic update_ir;
    logic capture_dr;
    logic shift_dr;
    logic update_dr;
    logic select_ir;
    logic ir_tdo;
    logic dr_tdo;
    logic sel_idcode;
    logic sel_tdr;
    logic sel_status;
    logic tdr_access_en;
    logic [stap_secure_pkg::POLICY_WIDTH-1:0] policy_q;

    // ------------------------------
    // TAP controller
    // ------------------------------
    stap_tap_fsm i_tap_fsm (
        .ftap_tck   (ftap_tck),
        .rst_n      (rst_n),
        .ftap_tms   (ftap_tms),
        .tap_reset  (tap_reset),
        .capture_ir (capture_ir),
        .shift_ir   (shift_ir),
        .update_ir  (update_ir),
        .capture_dr (capture_dr),
        .shift_dr   (shift_dr),
        .update_dr  (update_dr),
        .select_ir  (select_ir)
    );

    // Instruction register and decode
    stap_instr_reg i_instr_reg (
        .ftap_tck   (ftap_tck),
        .rst_n      (rst_n),
        .ftap_tdi   (ftap_tdi),
        .tap_reset  (tap_reset),
        .capture_ir (capture_ir),
        .shift_ir   (shift_ir),
        .update_ir  (update_ir),
        .ir_tdo     (ir_tdo),
        .sel_idcode (sel_idcode),
        .sel_tdr    (sel_tdr),
        .sel_status (sel_status)
    );

    // Security plugin
    stap_secure_plugin i_secure_plugin (
        .ftap_tck             (ftap_tck),
        .rst_n                (rst_n),
        .fdfx_secure_policy   (fdfx_secure_policy),
        .fdfx_policy_update   (fdfx_policy_update),
        .fdfx_earlyboot_exit  (fdfx_earlyboot_exit),
        .policy_q             (policy_q),
        .tdr_access_en        (tdr_access_en),
        .dfxsecure_feature_en (dfxsecure_feature_en)
    );

    // Data register bank
    stap_dr_bank #(
        .TDR_WIDTH    (TDR_WIDTH),
        .IDCODE_VALUE (IDCODE_VALUE)
    ) i_dr_bank (
        .ftap_tck      (ftap_tck),
        .rst_n         (rst_n),
        .ftap_tdi      (ftap_tdi),
        .capture_dr    (capture_dr),
        .shift_dr      (shift_dr),
        .update_dr     (update_dr),
        .sel_idcode    (sel_idcode),
        .sel_tdr       (sel_tdr),
        .sel_status    (sel_status),
        .tdr_access_en (tdr_access_en),
        .policy_q      (policy_q),
        .tdr_data_in   (tdr_data_in),
        .dr_tdo        (dr_tdo),
        .tdr_data_out  (tdr_data_out)
    );

    // ------------------------------
    // TDO output stage
    // ------------------------------

    // IR chain in the IR column, DR chain everywhere else
    assign atap_tdo = select_ir ? ir_tdo : dr_tdo;

endmodule

// ==== dv/stap_asserts.sv ====
module stap_asserts (
    input logic       ftap_tck,
    input logic       rst_n,
    input logic       ftap_tms,
    input logic [3:0] state,
    input logic       capture_ir,
    input logic       shift_ir,
    input logic       update_ir,
    input logic       capture_dr,
    input logic       shift_dr,
    input logic       update_dr
);

    timeunit 1ns;
    timeprecision 1ps;

    import stap_jtag_pkg::*;

    // ------------------------------
    // TAP controller properties
    // ------------------------------

    // Capture, shift and update strobes never overlap
    a_strobe_onehot: assert property (@(posedge ftap_tck)
        $onehot0({capture_ir, shift_ir, update_ir, capture_dr, shift_dr, update_dr}))
        else $error("More than one TAP strobe high in state %h", state);

    // Synchronous reset lands in Test-Logic-Reset
    a_rst_to_tlr: assert property (@(posedge ftap_tck)
        !rst_n |=> (state == TEST_LOGIC_RESET))
        else $error("State %h one cycle after rst_n low", state);

    // Five TMS-high edges reach Test-Logic-Reset from anywhere
    a_tms_to_tlr: assert property (@(posedge ftap_tck)
        (ftap_tms && $past(ftap_tms, 1) && $past(ftap_tms, 2) &&
         $past(ftap_tms, 3) && $past(ftap_tms, 4)) |=> (state == TEST_LOGIC_RESET))
        else $error("State %h after five TMS-high edges", state);

endmodule

bind stap_tap_fsm stap_asserts u_asserts (
    .ftap_tck   (ftap_tck),
    .rst_n      (rst_n),
    .ftap_tms   (ftap_tms),
    .state      (state),
    .capture_ir (capture_ir),
    .shift_ir   (shift_ir),
    .update_ir  (update_ir),
    .capture_dr (capture_dr),
    .shift_dr   (shift_dr),
    .update_dr  (update_dr)
);

// ==== dv/stap_tb.sv ====
module stap_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import stap_secure_pkg::*;

    localparam int TDR_WIDTH   = 32;
    localparam int CLK_PERIOD  = 100;
    localparam int DRIVE_DELAY = 5;
    localparam int MAX_STEPS   = 32;

    // Step operations in the pattern file
    localparam int STEP_SET_POLICY  = 1;
    localparam int STEP_LOAD_IR     = 2;
    localparam int STEP_SCAN_DR     = 3;
    localparam int STEP_SCAN_IDCODE = 4;
    localparam int STEP_SCAN_TDR    = 5;
    localparam int STEP_TMS_RESET   = 6;

    logic                    ftap_tck;
    logic                    rst_n;
    logic                    ftap_tms;
    logic                    ftap_tdi;
    logic [POLICY_WIDTH-1:0] fdfx_secure_policy;
    logic                    fdfx_policy_update;
    logic                    fdfx_earlyboot_exit;
    logic [TDR_WIDTH-1:0]    tdr_data_in;
    logic                    atap_tdo;
    logic [TDR_WIDTH-1:0]    tdr_data_out;
    logic                    dfxsecure_feature_en;

    // Four words per step for op, length, data and expected
    logic [31:0]          pattern_mem [0:MAX_STEPS*4-1];
    logic [31:0]          rng_state      = 32'h798e_bd7a;
    logic [TDR_WIDTH-1:0] parallel_model = '0;
    int                   cycle_count    = 0;
    int                   cycle_limit    = 0;
    int                   error_count    = 0;

    stap_top uut (
        .ftap_tck             (ftap_tck),
        .rst_n                (rst_n),
        .ftap_tms             (ftap_tms),
        .ftap_tdi             (ftap_tdi),
        .fdfx_secure_policy   (fdfx_secure_policy),
        .fdfx_policy_update   (fdfx_policy_update),
        .fdfx_earlyboot_exit  (fdfx_earlyboot_exit),
        .tdr_data_in          (tdr_data_in),
        .atap_tdo             (atap_tdo),
        .tdr_data_out         (tdr_data_out),
        .dfxsecure_feature_en (dfxsecure_feature_en)
    );

    // ------------------------------
    // Clock and timeout
    // ------------------------------
    initial ftap_tck = 1'b0;
    always #(CLK_PERIOD / 2) ftap_tck = ~ftap_tck;

    // Limit is zero until the pattern file is sized
    always @(posedge ftap_tck) begin
        cycle_count = cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("Timeout: run exceeded %0d TCK cycles", cycle_limit);
            stop_with_failure();
        end
    end

    // ------------------------------
    // Helpers
    // ------------------------------
    task automatic stop_with_failure();
        $display("RESULT: FAIL");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    // Xorshift with shift amounts 13, 17 and 5
    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic check_tdo_word(input string name, input logic [TDR_WIDTH-1:0] got,
                                  input logic [TDR_WIDTH-1:0] exp);
        if (got !== exp) begin
            error_count++;
            $display("CHECK FAILED time %0t: %s got %h expected %h", $time, name, got, exp);
            stop_with_failure();
        end
    endtask

    task automatic check_parallel(input logic [TDR_WIDTH-1:0] got,
                                  input logic [TDR_WIDTH-1:0] exp);
        if (got !== exp) begin
            error_count++;
            $display("CHECK FAILED time %0t: tdr_data_out got %h expected %h",
                     $time, got, exp);
            stop_with_failure();
        end
    endtask

    task automatic check_flag(input logic got, input logic exp);
        if (got !== exp) begin
            error_count++;
            $display("CHECK FAILED time %0t: dfxsecure_feature_en got %b expected %b",
                     $time, got, exp);
            stop_with_failure();
        end
    endtask

    // ------------------------------
    // JTAG driver
    // ------------------------------

    // One TCK edge with inputs changed just after the rising edge
    task automatic tms_step(input logic tms);
        ftap_tms = tms;
        ftap_tdi = 1'b0;
        @(posedge ftap_tck);
        #DRIVE_DELAY;
    endtask

    // From Run-Test/Idle
    task automatic goto_shift_ir();
        tms_step(1'b1);
        tms_step(1'b1);
        tms_step(1'b0);
        tms_step(1'b0);
    endtask

    task automatic goto_shift_dr();
        tms_step(1'b1);
        tms_step(1'b0);
        tms_step(1'b0);
    endtask

    // Data goes in LSB first
    // TDO is sampled just before each rising edge
    // exit_last raises TMS on the final bit to leave through Exit1
    task automatic shift_bits(input int n, input logic [TDR_WIDTH-1:0] din,
                              input logic exit_last, output logic [TDR_WIDTH-1:0] dout);
        logic [TDR_WIDTH-1:0] captured;
        captured = '0;
        for (int i = 0; i < n; i++) begin
            ftap_tms = exit_last && (i == n - 1);
            ftap_tdi = din[i];
            #(CLK_PERIOD - 2 * DRIVE_DELAY);
            captured[i] = atap_tdo;
            @(posedge ftap_tck);
            #DRIVE_DELAY;
        end
        dout = captured;
    endtask

    // Exit1 to Update and back to Idle
    task automatic exit_through_update();
        tms_step(1'b1);
        tms_step(1'b0);
    endtask

    // ------------------------------
    // Pattern replay
    // ------------------------------
    task automatic run_step(input logic [31:0] op, input int len,
                            input logic [31:0] data, input logic [31:0] exp);
        logic [TDR_WIDTH-1:0] scanned;
        logic [TDR_WIDTH-1:0] payload;
        logic [TDR_WIDTH-1:0] expected;
        logic [31:0]          idcode_exp;
        case (op)
            STEP_SET_POLICY: begin
                fdfx_secure_policy  = data[POLICY_WIDTH-1:0];
                fdfx_earlyboot_exit = data[4];
                fdfx_policy_update  = 1'b1;
                tms_step(1'b0);
                fdfx_policy_update  = 1'b0;
                // Decision settles one cycle after the latch
                tms_step(1'b0);
                check_flag(dfxsecure_feature_en, exp[0]);
            end
            STEP_LOAD_IR: begin
                goto_shift_ir();
                shift_bits(len, data, 1'b1, scanned);
                exit_through_update();
                check_tdo_word("atap_tdo IR chain", scanned, exp);
            end
            STEP_SCAN_DR: begin
                goto_shift_dr();
                shift_bits(len, data, 1'b1, scanned);
                exit_through_update();
                check_tdo_word("atap_tdo DR chain", scanned, exp);
            end
            STEP_SCAN_IDCODE: begin
                idcode_exp    = uut.IDCODE_VALUE;
                idcode_exp[0] = 1'b1;
                goto_shift_dr();
                shift_bits(len, data, 1'b1, scanned);
                exit_through_update();
                check_tdo_word("atap_tdo IDCODE", scanned, idcode_exp);
            end
            STEP_SCAN_TDR: begin
                if (len != TDR_WIDTH) begin
                    $display("TDR step has length %0d, a full %0d-bit scan is needed",
                             len, TDR_WIDTH);
                    stop_with_failure();
                end
                rng_state   = xorshift32(rng_state);
                tdr_data_in = rng_state;
                rng_state   = xorshift32(rng_state);
                payload     = rng_state;
                goto_shift_dr();
                shift_bits(len, payload, 1'b1, scanned);
                exit_through_update();
                // Open TDR returns the parallel input
                // A locked one acts as bypass
                if (exp[0]) begin
                    expected       = tdr_data_in;
                    parallel_model = payload;
                end else begin
                    expected = {payload[TDR_WIDTH-2:0], 1'b0};
                end
                check_tdo_word("atap_tdo TDR", scanned, expected);
                check_parallel(tdr_data_out, parallel_model);
                check_flag(dfxsecure_feature_en, exp[0]);
            end
            STEP_TMS_RESET: begin
                // Leaves the scan half done and forces Test-Logic-Reset
                goto_shift_dr();
                shift_bits(len, data, 1'b0, scanned);
                repeat (5) tms_step(1'b1);
                tms_step(1'b0);
            end
            default: begin
                $display("Pattern file holds an unknown operation %0h", op);
                stop_with_failure();
            end
        endcase
    endtask

    // ------------------------------
    // Main sequence
    // ------------------------------
    initial begin
        int step_count;
        int len_sum;
        rst_n               = 1'b0;
        ftap_tms            = 1'b0;
        ftap_tdi            = 1'b0;
        fdfx_secure_policy  = POLICY_LOCKED;
        fdfx_policy_update  = 1'b0;
        fdfx_earlyboot_exit = 1'b0;
        tdr_data_in         = '0;
        for (int i = 0; i < MAX_STEPS * 4; i++) begin
            pattern_mem[i] = '0;
        end
        $readmemh("dv/stap_patterns.hex", pattern_mem);

        // Zero op marks the end of the steps
        step_count = 0;
        len_sum    = 0;
        while (step_count < MAX_STEPS && pattern_mem[4 * step_count] != 0) begin
            len_sum = len_sum + int'(pattern_mem[4 * step_count + 1]);
            step_count++;
        end
        if (step_count == 0) begin
            $display("No test steps found in dv/stap_patterns.hex");
            stop_with_failure();
        end
        cycle_limit = 2 * len_sum + 200;

        repeat (8) @(posedge ftap_tck);
        #DRIVE_DELAY;
        rst_n = 1'b1;
        check_parallel(tdr_data_out, '0);
        check_flag(dfxsecure_feature_en, 1'b0);
        // Test-Logic-Reset to Idle
        tms_step(1'b0);

        for (int s = 0; s < step_count; s++) begin
            run_step(pattern_mem[4 * s], int'(pattern_mem[4 * s + 1]),
                     pattern_mem[4 * s + 2], pattern_mem[4 * s + 3]);
        end

        if (error_count == 0) begin
            $display("RESULT: PASS");
            $finish;
        end else begin
            stop_with_failure();
        end
    end

endmodule

// ==== dv/stap_patterns.hex ====
// Columns: operation, length in bits, shift-in data, expected TDO word or flag
// Operations: 1 policy, 2 IR load, 3 DR scan, 4 IDCODE scan, 5 random TDR scan, 6 TMS reset
4 20 00000000 00000000
2 04 0000000F 00000001
3 20 12345678 2468ACF0
// Opcode 3 is not decoded and falls to bypass
2 04 00000003 00000001
3 20 A5A5A5A5 4B4B4B4A
1 00 00000002 00000001
2 04 00000008 00000001
5 20 00000000 00000001
1 00 00000000 00000000
5 20 00000000 00000000
1 00 00000001 00000001
5 20 00000000 00000001
// Default policy with early boot done, bit 4 of the data is the exit level
1 00 00000011 00000000
5 20 00000000 00000000
2 04 00000009 00000001
3 08 00000000 00000001
1 00 00000002 00000001
3 08 000000FF 00000012
2 04 00000008 00000001
6 0A 00000155 00000000
4 20 FFFFFFFF 00000000

// ==== files.f ====
hdl/stap_jtag_pkg.sv
hdl/stap_secure_pkg.sv
hdl/stap_tap_fsm.sv
hdl/stap_instr_reg.sv
hdl/stap_secure_plugin.sv
hdl/stap_dr_bank.sv
hdl/stap_top.sv
dv/stap_asserts.sv
dv/stap_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the STAP testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module stap_tb -f files.f -o stap_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/stap_sim > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi

# The log decides the outcome
if grep -q "^RESULT: PASS$" sim.log; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed, see sim.log"
    exit 1
fi
